/* common/sys_pkg.sv */
// System-control package
// CPU bus, device select, read-data and clock-enable types plus the
// divider phases and memory-map constants shared by the control core
`default_nettype none

package sys_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  pix_cnt_t;
	typedef logic [5:0]  phase_t;

	// CPU side of the bus, write strobe active low
	typedef struct packed {
		addr_t addr;
		byte_t dout;
		logic  wr_n;
		logic  rd;
	} cpu_bus_t;

	typedef struct packed {
		logic ppa1;
		logic ppa2;
		logic pit;
		logic crt;
		logic dma;
	} dev_sel_t;

	// Read bytes coming back from the external chips and ROMs
	typedef struct packed {
		byte_t pit;
		byte_t ppa1;
		byte_t ppa2;
		byte_t crt;
		byte_t rom;
		byte_t rom86;
	} dev_rdata_t;

	typedef struct packed {
		logic f1;
		logic f2;
		logic pix;
		logic pit;
		logic lpf;
	} ce_t;

	// Dividers
	localparam int unsigned PIX_DIV = 12;
	localparam int unsigned CPU_DIV = 54;

	localparam phase_t PH_F1     = 6'd0;
	localparam phase_t PH_F2     = 6'd13;
	localparam phase_t PH_F1_ALT = 6'd27;
	localparam phase_t PH_F2_ALT = 6'd40;
	localparam phase_t PH_PIT    = 6'd8;

	// Apogee I/O pages and ROM window
	localparam byte_t APO_PIT_PAGE  = 8'hEC;
	localparam byte_t APO_PPA1_PAGE = 8'hED;
	localparam byte_t APO_PPA2_PAGE = 8'hEE;
	localparam byte_t APO_CRT_PAGE  = 8'hEF;
	localparam byte_t APO_ROM_PAGE  = 8'hF0;

	// Radio-86RK window bases
	localparam addr_t RK_PPA1_BASE = 16'h8000;
	localparam addr_t RK_PIT_BASE  = 16'hA000;
	localparam addr_t RK_NONE_BASE = 16'hA800;
	localparam addr_t RK_CRT_BASE  = 16'hC000;
	localparam addr_t RK_DMA_BASE  = 16'hE000;
	localparam addr_t RK_ROM_BASE  = 16'hF000;

	localparam int unsigned RESET_STRETCH = 16;

endpackage

`default_nettype wire

/* common/load_pkg.sv */
// Loader package
// Download port and RAM fill types, RK tape-file constants
`default_nettype none

package load_pkg;

	// Byte stream from the host side
	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_port_t;

	// One RAM write from the loader
	typedef struct packed {
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  data;
	} fill_t;

	// 8080 JMP, placed at address 0 ahead of the start address
	localparam logic [7:0] JMP_OPCODE = 8'hC3;

	// Indices whose files lack the leading sync byte
	localparam logic [1:0][7:0] RK_OFFSET_INDICES = {8'h41, 8'h01};

	// Index from which a download selects the Radio-86RK map
	localparam logic [7:0] MODE86_MIN_INDEX = 8'd2;

	// Last byte of the jump stub, kept during the erase
	localparam logic [15:0] STUB_END = 16'd2;

endpackage

`default_nettype wire

/* hdl/ce_gen.sv */
// Clock-enable generator
// Pixel enable every 12 cycles and the two-phase CPU enables over a
// 54-cycle frame, with the turbo doubling taken at the frame wrap
`timescale 1ns/1ps
`default_nettype none

module ce_gen import sys_pkg::*; (
	input  wire logic clk_sys,
	input  wire logic reset_key,
	input  wire logic turbo_i,
	output ce_t       ce_o
);

	localparam pix_cnt_t PIX_LAST   = pix_cnt_t'(PIX_DIV - 1);
	localparam phase_t   PHASE_LAST = phase_t'(CPU_DIV - 1);

	pix_cnt_t pix_cnt;
	phase_t   phase;
	logic     turbo_q;

	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			pix_cnt <= '0;
			phase   <= '0;
			turbo_q <= 1'b0;
			ce_o    <= '0;
		end else begin
			if (pix_cnt == PIX_LAST)
				pix_cnt <= '0;
			else
				pix_cnt <= pix_cnt + 4'd1;

			// Turbo only changes between frames
			if (phase == PHASE_LAST) begin
				phase   <= '0;
				turbo_q <= turbo_i;
			end else begin
				phase <= phase + 6'd1;
			end

			ce_o.pix <= (pix_cnt == '0);
			ce_o.f1  <= (phase == PH_F1) | (turbo_q & (phase == PH_F1_ALT));
			ce_o.f2  <= (phase == PH_F2) | (turbo_q & (phase == PH_F2_ALT));
			ce_o.pit <= (phase == PH_PIT);
			ce_o.lpf <= (phase == PH_F1) | (phase == PH_F1_ALT);
		end
	end

endmodule

`default_nettype wire

/* hdl/reset_seq.sv */
// Reset sequencer
// Holds the CPU in reset while any request is present and for a fixed
// stretch after the last one goes away
`timescale 1ns/1ps
`default_nettype none

module reset_seq import sys_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset_key,
	input  wire logic [2:0] kbd_reset_i,
	input  wire logic       soft_reset_i,
	input  wire logic       filling_i,
	output logic            cpu_reset_o
);

	localparam int unsigned CNT_W = $clog2(RESET_STRETCH);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_STRETCH - 1);

	logic             req;
	logic [CNT_W-1:0] stretch_q;

	// Any source restarts the stretch
	assign req = reset_key | (|kbd_reset_i) | soft_reset_i | filling_i;

	always_ff @(posedge clk_sys) begin
		if (req) begin
			cpu_reset_o <= 1'b1;
			stretch_q   <= '0;
		end else if (stretch_q != CNT_LAST) begin
			stretch_q <= stretch_q + 1'b1;
		end else begin
			cpu_reset_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/addr_decode.sv */
// Address decoder
// Keeps the machine mode and the startup ROM overlay, decodes the CPU
// address into chip selects and picks the byte returned to the CPU
`timescale 1ns/1ps
`default_nettype none

module addr_decode import sys_pkg::*, load_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset_key,
	input  wire logic       cpu_reset_i,
	input  wire cpu_bus_t   cpu_i,
	input  wire dl_port_t   dl_i,
	input  wire logic [2:0] kbd_reset_i,
	input  wire byte_t      ram_q_i,
	input  wire dev_rdata_t dev_i,
	output dev_sel_t        sel_o,
	output byte_t           cpu_din_o,
	output logic            mode86_o
);

	typedef enum logic [2:0] {
		SRC_RAM, SRC_ZERO, SRC_PIT, SRC_PPA1, SRC_PPA2, SRC_CRT, SRC_ROM, SRC_ROM86
	} src_t;

	logic       dl_active_q;
	logic       startup_q;
	logic       overlay;
	src_t       src;
	src_t       src_q;
	dev_rdata_t dev_q;
	addr_t      a;

	assign a = cpu_i.addr;
	// Overlay takes effect as soon as the CPU enters reset
	assign overlay = startup_q | cpu_reset_i;

	// Mode and overlay state --------------
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			dl_active_q <= 1'b0;
			mode86_o    <= 1'b0;
			startup_q   <= 1'b1;
		end else begin
			dl_active_q <= dl_i.active;
			if (dl_i.active & ~dl_active_q)
				mode86_o <= (dl_i.index >= MODE86_MIN_INDEX);
			// Keyboard reset keys override the download choice
			if (|kbd_reset_i)
				mode86_o <= kbd_reset_i[2];
			startup_q <= cpu_reset_i | (startup_q & ~a[15]);
		end
	end

	// Address map --------------------------
	always_comb begin
		sel_o = '0;
		src   = SRC_RAM;
		if (overlay) begin
			src = mode86_o ? SRC_ROM86 : SRC_ROM;
		end else if (mode86_o) begin
			if (a >= RK_ROM_BASE) begin
				src = SRC_ROM86;
			end else if (a >= RK_DMA_BASE) begin
				src       = SRC_ROM86;
				sel_o.dma = 1'b1;
			end else if (a >= RK_CRT_BASE) begin
				src       = SRC_CRT;
				sel_o.crt = 1'b1;
			end else if (a >= RK_NONE_BASE) begin
				src = SRC_ZERO;
			end else if (a >= RK_PIT_BASE) begin
				src       = SRC_PIT;
				sel_o.pit = 1'b1;
			end else if (a >= RK_PPA1_BASE) begin
				src        = SRC_PPA1;
				sel_o.ppa1 = 1'b1;
			end
		end else begin
			case (a[15:8])
				APO_PIT_PAGE:  begin src = SRC_PIT;  sel_o.pit  = 1'b1; end
				APO_PPA1_PAGE: begin src = SRC_PPA1; sel_o.ppa1 = 1'b1; end
				APO_PPA2_PAGE: begin src = SRC_PPA2; sel_o.ppa2 = 1'b1; end
				APO_CRT_PAGE:  begin src = SRC_CRT;  sel_o.crt  = 1'b1; end
				default: begin
					// Top 4K is ROM, DMA registers share its first page
					if (a[15:12] == APO_ROM_PAGE[7:4]) begin
						src       = SRC_ROM;
						sel_o.dma = (a[15:8] == APO_ROM_PAGE);
					end
				end
			endcase
		end
	end

	// Read data lines up with the synchronous RAM
	always_ff @(posedge clk_sys) begin
		if (reset_key)
			src_q <= SRC_RAM;
		else
			src_q <= src;
		dev_q <= dev_i;
	end

	always_comb begin
		case (src_q)
			SRC_ZERO:  cpu_din_o = '0;
			SRC_PIT:   cpu_din_o = dev_q.pit;
			SRC_PPA1:  cpu_din_o = dev_q.ppa1;
			SRC_PPA2:  cpu_din_o = dev_q.ppa2;
			SRC_CRT:   cpu_din_o = dev_q.crt;
			SRC_ROM:   cpu_din_o = dev_q.rom;
			SRC_ROM86: cpu_din_o = dev_q.rom86;
			default:   cpu_din_o = ram_q_i;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/main_ram.sv */
// Main RAM, 64 KB
// Single synchronous port, owned by the loader while it fills and by
// the CPU the rest of the time
`timescale 1ns/1ps
`default_nettype none

module main_ram import sys_pkg::*, load_pkg::*; (
	input  wire logic     clk_sys,
	input  wire logic     filling_i,
	input  wire fill_t    fill_i,
	input  wire cpu_bus_t cpu_i,
	output byte_t         q_o
);

	localparam int unsigned RAM_WORDS = 2 ** $bits(addr_t);

	byte_t mem [0:RAM_WORDS-1];
	addr_t addr;
	byte_t din;
	logic  we;

	// Port owner
	always_comb begin
		if (filling_i) begin
			addr = fill_i.addr;
			din  = fill_i.data;
			we   = fill_i.wr;
		end else begin
			addr = cpu_i.addr;
			din  = cpu_i.dout;
			we   = ~cpu_i.wr_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= din;
		q_o <= mem[addr];
	end

endmodule

`default_nettype wire

/* rk_loader/rk_loader.sv */
// RK tape-file loader
// Turns a downloaded RK file into RAM writes: a JMP stub at 0..2, the
// body at its load address, then zeroes the rest of RAM at a slow pace
`timescale 1ns/1ps
`default_nettype none

module rk_loader import load_pkg::*; #(
	parameter int unsigned ERASE_DIV_BITS = 6
) (
	input  wire logic     clk_sys,
	input  wire logic     reset_key,
	input  wire dl_port_t dl_i,
	output fill_t         fill_o,
	output logic          filling_o
);

	logic                      offset;
	logic [24:0]               pos;
	logic [7:0]                start_hi;
	logic [7:0]                start_lo;
	logic [15:0]               body_ptr;
	logic [15:0]               erase_addr;
	logic [ERASE_DIV_BITS-1:0] erase_div;
	logic                      erase_pending;
	logic                      erasing;

	// Files without the sync byte start one position later
	assign offset = (dl_i.index == RK_OFFSET_INDICES[0]) |
	                (dl_i.index == RK_OFFSET_INDICES[1]);
	assign pos = dl_i.addr + {24'd0, offset};

	assign filling_o = dl_i.active | erase_pending | erasing;

	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			fill_o.wr     <= 1'b0;
			erase_pending <= 1'b0;
			erasing       <= 1'b0;
		end else begin
			fill_o.wr <= 1'b0;

			if (dl_i.active) begin
				erasing       <= 1'b0;
				erase_pending <= 1'b1;
				if (dl_i.wr) begin
					case (pos)
						25'd0: begin
							// Sync byte
						end
						25'd1: begin
							start_hi    <= dl_i.data;
							fill_o.addr <= 16'd0;
							fill_o.data <= JMP_OPCODE;
							fill_o.wr   <= 1'b1;
						end
						25'd2: begin
							start_lo    <= dl_i.data;
							fill_o.addr <= 16'd1;
							fill_o.data <= dl_i.data;
							fill_o.wr   <= 1'b1;
						end
						25'd3: begin
							fill_o.addr <= STUB_END;
							fill_o.data <= start_hi;
							fill_o.wr   <= 1'b1;
						end
						25'd4: begin
							body_ptr <= {start_hi, start_lo};
						end
						default: begin
							fill_o.addr <= body_ptr;
							fill_o.data <= dl_i.data;
							fill_o.wr   <= 1'b1;
							body_ptr    <= body_ptr + 16'd1;
						end
					endcase
				end
			end else if (erase_pending) begin
				// Erase runs from just past the body round to the start
				erase_pending <= 1'b0;
				erasing       <= 1'b1;
				erase_addr    <= body_ptr;
				erase_div     <= ERASE_DIV_BITS'(1);
			end else if (erasing) begin
				erase_div <= erase_div + 1'b1;
				if (erase_div == '0) begin
					if (erase_addr == {start_hi, start_lo}) begin
						erasing <= 1'b0;
					end else begin
						fill_o.addr <= erase_addr;
						fill_o.data <= 8'd0;
						// Keep the jump stub
						fill_o.wr   <= (erase_addr > STUB_END);
						erase_addr  <= erase_addr + 16'd1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/apogee_ctrl.sv */
// Apogee BK-01 / Radio-86RK system-control core
// Clock enables, reset sequencing, memory map, main RAM and the RK
// file loader; the CPU and peripheral chips sit outside
`timescale 1ns/1ps
`default_nettype none

module apogee_ctrl import sys_pkg::*, load_pkg::*; #(
	parameter int unsigned ERASE_DIV_BITS = 6
) (
	input  wire logic       clk_sys,
	input  wire logic       reset_key,
	input  wire cpu_bus_t   cpu_i,
	input  wire dl_port_t   dl_i,
	input  wire dev_rdata_t dev_i,
	input  wire logic       turbo_i,
	input  wire logic       soft_reset_i,
	input  wire logic [2:0] kbd_reset_i,
	output ce_t             ce_o,
	output logic            cpu_reset_o,
	output dev_sel_t        sel_o,
	output byte_t           cpu_din_o,
	output logic            mode86_o,
	output logic            filling_o
);

	fill_t fill;
	byte_t ram_q;

	ce_gen ce_gen_i (
		.clk_sys   (clk_sys),
		.reset_key (reset_key),
		.turbo_i   (turbo_i),
		.ce_o      (ce_o)
	);

	reset_seq reset_seq_i (
		.clk_sys      (clk_sys),
		.reset_key    (reset_key),
		.kbd_reset_i  (kbd_reset_i),
		.soft_reset_i (soft_reset_i),
		.filling_i    (filling_o),
		.cpu_reset_o  (cpu_reset_o)
	);

	addr_decode addr_decode_i (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.cpu_reset_i (cpu_reset_o),
		.cpu_i       (cpu_i),
		.dl_i        (dl_i),
		.kbd_reset_i (kbd_reset_i),
		.ram_q_i     (ram_q),
		.dev_i       (dev_i),
		.sel_o       (sel_o),
		.cpu_din_o   (cpu_din_o),
		.mode86_o    (mode86_o)
	);

	main_ram main_ram_i (
		.clk_sys   (clk_sys),
		.filling_i (filling_o),
		.fill_i    (fill),
		.cpu_i     (cpu_i),
		.q_o       (ram_q)
	);

	rk_loader #(
		.ERASE_DIV_BITS (ERASE_DIV_BITS)
	) rk_loader_i (
		.clk_sys   (clk_sys),
		.reset_key (reset_key),
		.dl_i      (dl_i),
		.fill_o    (fill),
		.filling_o (filling_o)
	);

endmodule

`default_nettype wire

/* tests/apogee_ctrl_assertions.sv */
// Bound checks on the control core
// CPU phase exclusivity, quiet selects in reset and loader writes only
// while filling
`timescale 1ns/1ps
`default_nettype none

module apogee_ctrl_assertions import sys_pkg::*; (
	input wire logic     clk_sys,
	input wire logic     reset_key,
	input wire ce_t      ce_i,
	input wire logic     cpu_reset_i,
	input wire dev_sel_t sel_i,
	input wire logic     fill_wr_i,
	input wire logic     filling_i
);

	// Number of failed checks
	int unsigned fail_count = 0;

	f1_f2_apart: assert property (@(posedge clk_sys) disable iff (reset_key)
		!(ce_i.f1 && ce_i.f2))
		else begin
			$error("f1 and f2 enables high together");
			fail_count++;
		end

	// Chips stay deselected while the CPU is held
	no_sel_in_reset: assert property (@(posedge clk_sys) disable iff (reset_key)
		cpu_reset_i |-> (sel_i == '0))
		else begin
			$error("device select active during CPU reset");
			fail_count++;
		end

	fill_in_window: assert property (@(posedge clk_sys) disable iff (reset_key)
		fill_wr_i |-> filling_i)
		else begin
			$error("loader write outside the filling window");
			fail_count++;
		end

endmodule

bind apogee_ctrl apogee_ctrl_assertions apogee_ctrl_assertions_i (
	.clk_sys     (clk_sys),
	.reset_key   (reset_key),
	.ce_i        (ce_o),
	.cpu_reset_i (cpu_reset_o),
	.sel_i       (sel_o),
	.fill_wr_i   (fill.wr),
	.filling_i   (filling_o)
);

`default_nettype wire

/* tests/tb_apogee_ctrl.sv */
// Testbench for the Apogee / Radio-86RK system-control core
// Covers clock enables, reset stretch, startup overlay, both address
// maps and an RK download with the following RAM erase
`timescale 1ns/1ps
`default_nettype none

module tb_apogee_ctrl import sys_pkg::*, load_pkg::*; ();

	localparam int ERASE_DIV_BITS = 1;
	localparam int ERASE_CYCLES   = 65536 << ERASE_DIV_BITS;
	localparam int FILL_TIMEOUT   = ERASE_CYCLES + 1000;
	// Sum of all test lengths, doubled for margin
	localparam int WATCHDOG_CYCLES = 2 * (8 + 4 * 540 + 4 * 200 * 2 + 400 + FILL_TIMEOUT);

	logic       clk_sys = 1'b0;
	logic       reset_key;
	cpu_bus_t   cpu;
	dl_port_t   dl;
	dev_rdata_t dev;
	logic       turbo;
	logic       soft_reset;
	logic [2:0] kbd;
	ce_t        ce;
	logic       cpu_reset;
	dev_sel_t   sel;
	byte_t      cpu_din;
	logic       mode86;
	logic       filling;

	int    errors;
	int    test_errors;
	int    seed = 74;
	// RK file without its sync byte: start 3012, end 3015, then the body
	byte_t rk_file [8] = '{8'h30, 8'h12, 8'h30, 8'h15, 8'h11, 8'h22, 8'h33, 8'h44};

	apogee_ctrl #(.ERASE_DIV_BITS(ERASE_DIV_BITS)) apogee_ctrl_i (
		.clk_sys(clk_sys), .reset_key(reset_key), .cpu_i(cpu), .dl_i(dl), .dev_i(dev),
		.turbo_i(turbo), .soft_reset_i(soft_reset), .kbd_reset_i(kbd), .ce_o(ce),
		.cpu_reset_o(cpu_reset), .sel_o(sel), .cpu_din_o(cpu_din), .mode86_o(mode86),
		.filling_o(filling)
	);

	always #5 clk_sys = ~clk_sys;

	// Reference models ---------------------
	function automatic dev_sel_t expected_sel(addr_t a, logic m86);
		dev_sel_t s;
		s = '0;
		if (m86) begin
			if (a >= 16'hF000) s = '0;
			else if (a >= 16'hE000) s.dma = 1'b1;
			else if (a >= 16'hC000) s.crt = 1'b1;
			else if (a >= 16'hA800) s = '0;
			else if (a >= 16'hA000) s.pit = 1'b1;
			else if (a >= 16'h8000) s.ppa1 = 1'b1;
		end else begin
			s.pit  = (a[15:8] == 8'hEC);
			s.ppa1 = (a[15:8] == 8'hED);
			s.ppa2 = (a[15:8] == 8'hEE);
			s.crt  = (a[15:8] == 8'hEF);
			s.dma  = (a[15:8] == 8'hF0);
		end
		return s;
	endfunction

	// Byte the CPU should see, or -1 where the address is plain RAM
	function automatic int expected_read(addr_t a, logic m86, dev_rdata_t d);
		if (m86) begin
			if (a >= 16'hE000) return d.rom86;
			if (a >= 16'hC000) return d.crt;
			if (a >= 16'hA800) return 0;
			if (a >= 16'hA000) return d.pit;
			if (a >= 16'h8000) return d.ppa1;
			return -1;
		end
		case (a[15:8])
			8'hEC: return d.pit;
			8'hED: return d.ppa1;
			8'hEE: return d.ppa2;
			8'hEF: return d.crt;
			default: return (a[15:12] == 4'hF) ? int'(d.rom) : -1;
		endcase
	endfunction

	function automatic int expected_pulses(int cycles, int period, int per_period);
		return (cycles / period) * per_period;
	endfunction

	function automatic byte_t expected_ram(addr_t a);
		int start;
		start = {rk_file[0], rk_file[1]};
		if (a == 16'd0) return 8'hC3;
		if (a == 16'd1) return rk_file[1];
		if (a == 16'd2) return rk_file[0];
		if (int'(a) >= start && int'(a) < start + 4) return rk_file[4 + int'(a) - start];
		return 8'h00;
	endfunction

	// Compare tasks ------------------------
	task automatic compare_sel(dev_sel_t got, dev_sel_t exp, string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s selects %b, expected %b", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic verify_byte(byte_t got, byte_t exp, string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) begin
			$display("[FAIL] %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(string name);
		$display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	// Bus helpers --------------------------
	task automatic read_cycle(addr_t a, output dev_sel_t s, output byte_t q);
		@(posedge clk_sys);
		cpu.addr <= a;
		cpu.wr_n <= 1'b1;
		cpu.rd   <= 1'b1;
		@(negedge clk_sys);
		s = sel;
		@(posedge clk_sys);
		cpu.rd <= 1'b0;
		@(negedge clk_sys);
		q = cpu_din;
	endtask

	task automatic write_cycle(addr_t a, byte_t d);
		@(posedge clk_sys);
		cpu.addr <= a;
		cpu.dout <= d;
		cpu.wr_n <= 1'b0;
		@(posedge clk_sys);
		cpu.wr_n <= 1'b1;
	endtask

	// Counts cycles from the release edge until the CPU reset drops
	task automatic await_reset_drop(output int n);
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
		end while (cpu_reset && n < 200);
		if (cpu_reset) begin
			$display("CPU reset never dropped after the request ended");
			test_errors++;
		end
	endtask

	task automatic pulse_kbd(logic [2:0] keys, output int n);
		@(posedge clk_sys);
		kbd <= keys;
		repeat (3) @(posedge clk_sys);
		kbd <= 3'b000;
		await_reset_drop(n);
	endtask

	task automatic count_enables(int cycles, output int pix, output int f1, output int f2,
	                             output int pit, output int lpf);
		pix = 0;
		f1  = 0;
		f2  = 0;
		pit = 0;
		lpf = 0;
		repeat (cycles) begin
			@(negedge clk_sys);
			pix += ce.pix;
			f1  += ce.f1;
			f2  += ce.f2;
			pit += ce.pit;
			lpf += ce.lpf;
		end
	endtask

	task automatic random_decode(logic m86, string what);
		addr_t    a;
		dev_sel_t s;
		byte_t    q;
		int       exp;
		repeat (200) begin
			a = addr_t'($random(seed));
			read_cycle(a, s, q);
			compare_sel(s, expected_sel(a, m86), what);
			exp = expected_read(a, m86, dev);
			if (exp >= 0)
				verify_byte(q, byte_t'(exp), what);
		end
	endtask

	task automatic send_rk_file();
		@(posedge clk_sys);
		dl.active <= 1'b1;
		dl.index  <= 8'h01;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.addr <= 25'(i);
			dl.data <= rk_file[i];
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end
		dl.active <= 1'b0;
	endtask

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int       n;
		int       pix;
		int       f1;
		int       f2;
		int       pit;
		int       lpf;
		dev_sel_t s;
		byte_t    q;
		addr_t    probe [5] = '{16'h3016, 16'h0003, 16'h3011, 16'h7FFF, 16'hE000};

		errors      = 0;
		test_errors = 0;
		reset_key   = 1'b1;
		cpu         = '{addr: 16'h0000, dout: 8'h00, wr_n: 1'b1, rd: 1'b0};
		dl          = '0;
		dev         = '{pit: 8'hA1, ppa1: 8'hB2, ppa2: 8'hC3, crt: 8'hD4,
		                rom: 8'hE5, rom86: 8'hF6};
		turbo       = 1'b0;
		soft_reset  = 1'b0;
		kbd         = 3'b000;
		repeat (8) @(posedge clk_sys);
		reset_key <= 1'b0;

		// 1: clock enables, normal then turbo
		count_enables(540, pix, f1, f2, pit, lpf);
		check_count(pix, expected_pulses(540, 12, 1), "pix");
		check_count(f1, expected_pulses(540, 54, 1), "f1 normal");
		check_count(f2, expected_pulses(540, 54, 1), "f2 normal");
		check_count(pit, expected_pulses(540, 54, 1), "pit normal");
		check_count(lpf, expected_pulses(540, 54, 2), "lpf normal");
		@(posedge clk_sys);
		turbo <= 1'b1;
		repeat (2 * 54) @(posedge clk_sys);
		count_enables(540, pix, f1, f2, pit, lpf);
		check_count(pix, expected_pulses(540, 12, 1), "pix turbo");
		check_count(f1, expected_pulses(540, 54, 2), "f1 turbo");
		check_count(f2, expected_pulses(540, 54, 2), "f2 turbo");
		check_count(pit, expected_pulses(540, 54, 1), "pit turbo");
		check_count(lpf, expected_pulses(540, 54, 2), "lpf turbo");
		@(posedge clk_sys);
		turbo <= 1'b0;
		finish_test("clock enables");

		// 2: reset stretch and mode keys
		pulse_kbd(3'b100, n);
		check_count(n, 16, "reset stretch");
		verify_byte(byte_t'(mode86), 8'd1, "mode86 after key 2");
		pulse_kbd(3'b001, n);
		check_count(n, 16, "reset stretch");
		verify_byte(byte_t'(mode86), 8'd0, "mode86 after key 0");
		@(posedge clk_sys);
		soft_reset <= 1'b1;
		@(posedge clk_sys);
		soft_reset <= 1'b0;
		await_reset_drop(n);
		check_count(n, 16, "soft reset stretch");
		finish_test("reset stretch");

		// 3: startup overlay
		write_cycle(16'h0100, 8'h5A);
		read_cycle(16'h0100, s, q);
		verify_byte(q, dev.rom, "overlay");
		read_cycle(16'hF000, s, q);
		read_cycle(16'h0100, s, q);
		verify_byte(q, 8'h5A, "RAM after overlay");
		finish_test("startup overlay");

		// 4: both maps with random addresses
		random_decode(1'b0, "apogee map");
		pulse_kbd(3'b100, n);
		read_cycle(16'hF000, s, q);
		random_decode(1'b1, "radio map");
		finish_test("address decode");

		// 5: RK download and erase
		// Old contents at the probe spots, so the erase has something to clear
		foreach (probe[i])
			write_cycle(probe[i], 8'hA5);
		send_rk_file();
		n = 0;
		while (filling && n < FILL_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (filling) begin
			$display("Loader kept filling past its time limit");
			test_errors++;
		end
		await_reset_drop(n);
		verify_byte(byte_t'(mode86), 8'd0, "mode86 after load");
		read_cycle(16'hF000, s, q);
		for (int i = 0; i < 3; i++) begin
			read_cycle(addr_t'(i), s, q);
			verify_byte(q, expected_ram(addr_t'(i)), "jump stub");
		end
		for (int i = 0; i < 4; i++) begin
			read_cycle(16'h3012 + addr_t'(i), s, q);
			verify_byte(q, expected_ram(16'h3012 + addr_t'(i)), "body");
		end
		foreach (probe[i]) begin
			read_cycle(probe[i], s, q);
			verify_byte(q, expected_ram(probe[i]), "erased RAM");
		end
		finish_test("rk load");

		errors += int'(apogee_ctrl_i.apogee_ctrl_assertions_i.fail_count);
		$display("checks done: %0d errors in total", errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
common/sys_pkg.sv
common/load_pkg.sv
hdl/ce_gen.sv
hdl/reset_seq.sv
hdl/addr_decode.sv
hdl/main_ram.sv
rk_loader/rk_loader.sv
hdl/apogee_ctrl.sv
tests/apogee_ctrl_assertions.sv
tests/tb_apogee_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_apogee_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
